/* src/bus_pkg.sv */
// Bus package with ICB widths, the peripheral address map and fabric region codes
package bus_pkg;

  localparam int addr_w = 32;
  localparam int data_w = 32;

  typedef logic [addr_w-1:0] addr_t;
  typedef logic [data_w-1:0] data_t;

  // Each target region spans 64 KB
  localparam int region_w = 16;

  typedef logic [region_w-1:0] offset_t;

  localparam addr_t clint_base = 32'h0200_0000;
  localparam addr_t plic_base  = 32'h0C00_0000;

  // Target chosen by the fabric address decode
  typedef enum logic [1:0] {
    region_none  = 2'd0,
    region_clint = 2'd1,
    region_plic  = 2'd2
  } region_t;

endpackage

/* src/irq_pkg.sv */
// Interrupt package with PLIC source sizing and CLINT and PLIC register offsets
package irq_pkg;

  // Source 0 is reserved and external inputs are sources 1 to 7
  localparam int num_src  = 8;
  localparam int src_id_w = 3;
  localparam int prio_w   = 3;

  typedef logic [src_id_w-1:0] src_id_t;
  typedef logic [prio_w-1:0]   prio_t;
  typedef logic [num_src-1:0]  src_vec_t;

  ////////////////////////////////////////////////////////////////////
  // CLINT register offsets
  localparam bus_pkg::offset_t msip_off        = 16'h0000;
  localparam bus_pkg::offset_t mtimecmp_lo_off = 16'h4000;
  localparam bus_pkg::offset_t mtimecmp_hi_off = 16'h4004;
  localparam bus_pkg::offset_t mtime_lo_off    = 16'hBFF8;
  localparam bus_pkg::offset_t mtime_hi_off    = 16'hBFFC;

  ////////////////////////////////////////////////////////////////////
  // PLIC register offsets
  // Priority word of source n sits at prio_off + 4*n
  localparam bus_pkg::offset_t prio_off      = 16'h0000;
  localparam bus_pkg::offset_t pending_off   = 16'h1000;
  localparam bus_pkg::offset_t enable_off    = 16'h2000;
  localparam bus_pkg::offset_t threshold_off = 16'h3000;
  localparam bus_pkg::offset_t claim_off     = 16'h3004;

endpackage

/* src/clint_timer.sv */
// CLINT holding the machine timer, timer compare and software interrupt registers
`timescale 1ns/1ns

module clint_timer (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             sel,
  input  logic             reg_read,
  input  bus_pkg::offset_t reg_offset,
  input  bus_pkg::data_t   reg_wdata,
  output logic             rsp_valid,
  output logic             rsp_err,
  output bus_pkg::data_t   rsp_rdata,
  input  logic             rtc_toggle_a,
  output logic             tmr_irq,
  output logic             sft_irq
);

  import bus_pkg::*;
  import irq_pkg::*;

  logic [63:0] mtime;
  logic [63:0] mtimecmp;
  logic        msip;

  logic rtc_meta;
  logic rtc_sync;
  logic rtc_last;
  logic rtc_tick;

  logic  hit_msip;
  logic  hit_cmp_lo;
  logic  hit_cmp_hi;
  logic  hit_time_lo;
  logic  hit_time_hi;
  logic  hit_any;
  logic  wr_en;
  data_t rd_data;

  ////////////////////////////////////////////////////////////////////
  // RTC toggle synchronizer and rising edge detect
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rtc_meta <= 1'b0;
      rtc_sync <= 1'b0;
      rtc_last <= 1'b0;
    end else begin
      rtc_meta <= rtc_toggle_a;
      rtc_sync <= rtc_meta;
      rtc_last <= rtc_sync;
    end
  end

  assign rtc_tick = rtc_sync & ~rtc_last;

  ////////////////////////////////////////////////////////////////////
  // Register decode
  assign hit_msip    = (reg_offset == msip_off);
  assign hit_cmp_lo  = (reg_offset == mtimecmp_lo_off);
  assign hit_cmp_hi  = (reg_offset == mtimecmp_hi_off);
  assign hit_time_lo = (reg_offset == mtime_lo_off);
  assign hit_time_hi = (reg_offset == mtime_hi_off);
  assign hit_any     = hit_msip | hit_cmp_lo | hit_cmp_hi | hit_time_lo | hit_time_hi;
  assign wr_en       = sel & ~reg_read;

  // Bus write wins over a tick in the same cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mtime <= '0;
    end else if (wr_en && hit_time_lo) begin
      mtime[31:0] <= reg_wdata;
    end else if (wr_en && hit_time_hi) begin
      mtime[63:32] <= reg_wdata;
    end else if (rtc_tick) begin
      mtime <= mtime + 64'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mtimecmp <= '1;
      msip     <= 1'b0;
    end else if (wr_en) begin
      if (hit_cmp_lo) begin
        mtimecmp[31:0] <= reg_wdata;
      end
      if (hit_cmp_hi) begin
        mtimecmp[63:32] <= reg_wdata;
      end
      if (hit_msip) begin
        msip <= reg_wdata[0];
      end
    end
  end

  always_comb begin
    case (reg_offset)
      msip_off:        rd_data = {{(data_w-1){1'b0}}, msip};
      mtimecmp_lo_off: rd_data = mtimecmp[31:0];
      mtimecmp_hi_off: rd_data = mtimecmp[63:32];
      mtime_lo_off:    rd_data = mtime[31:0];
      mtime_hi_off:    rd_data = mtime[63:32];
      default:         rd_data = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////
  // One-cycle response pulse
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rsp_valid <= 1'b0;
      rsp_err   <= 1'b0;
    end else begin
      rsp_valid <= sel;
      rsp_err   <= sel & ~hit_any;
    end
  end

  always_ff @(posedge clk) begin
    if (sel) begin
      rsp_rdata <= reg_read ? rd_data : '0;
    end
  end

  assign tmr_irq = (mtime >= mtimecmp);
  assign sft_irq = msip;

endmodule

/* src/plic_core.sv */
// PLIC with source gateways, priority and enable registers, and claim and complete
`timescale 1ns/1ns

module plic_core (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              sel,
  input  logic              reg_read,
  input  bus_pkg::offset_t  reg_offset,
  input  bus_pkg::data_t    reg_wdata,
  output logic              rsp_valid,
  output logic              rsp_err,
  output bus_pkg::data_t    rsp_rdata,
  input  irq_pkg::src_vec_t irq_src_a,
  output logic              ext_irq
);

  import bus_pkg::*;
  import irq_pkg::*;

  src_vec_t src_meta;
  src_vec_t src_sync;
  src_vec_t pending;
  src_vec_t in_service;
  src_vec_t enable;
  prio_t    prio [num_src];
  prio_t    threshold;

  src_id_t  claim_id;
  prio_t    claim_prio;

  offset_t  prio_rel;
  src_id_t  prio_idx;
  logic     hit_prio;
  logic     hit_pending;
  logic     hit_enable;
  logic     hit_threshold;
  logic     hit_claim;
  logic     hit_any;
  logic     wr_en;
  logic     claim_rd;
  logic     complete_wr;
  src_id_t  complete_id;
  data_t    rd_data;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      src_meta <= '0;
      src_sync <= '0;
    end else begin
      src_meta <= irq_src_a;
      src_sync <= src_meta;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // One gateway per source and source 0 never pends
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pending    <= '0;
      in_service <= '0;
    end else begin
      for (int i = 1; i < num_src; i++) begin
        if (claim_rd && claim_id == src_id_t'(i)) begin
          pending[i]    <= 1'b0;
          in_service[i] <= 1'b1;
        end else begin
          if (src_sync[i] && !in_service[i]) begin
            pending[i] <= 1'b1;
          end
          if (complete_wr && complete_id == src_id_t'(i)) begin
            in_service[i] <= 1'b0;
          end
        end
      end
    end
  end

  // Highest priority above threshold with ties to the lowest id
  always_comb begin
    claim_id   = '0;
    claim_prio = threshold;
    for (int i = 1; i < num_src; i++) begin
      if (pending[i] && enable[i] && prio[i] > claim_prio) begin
        claim_id   = src_id_t'(i);
        claim_prio = prio[i];
      end
    end
  end

  assign ext_irq = (claim_id != '0);

  ////////////////////////////////////////////////////////////////////
  // Register decode
  assign prio_rel      = reg_offset - prio_off;
  assign prio_idx      = prio_rel[src_id_w+1:2];
  assign hit_prio      = (prio_rel < offset_t'(4 * num_src)) && (prio_rel[1:0] == 2'b00);
  assign hit_pending   = (reg_offset == pending_off);
  assign hit_enable    = (reg_offset == enable_off);
  assign hit_threshold = (reg_offset == threshold_off);
  assign hit_claim     = (reg_offset == claim_off);
  assign hit_any       = hit_prio | hit_pending | hit_enable | hit_threshold | hit_claim;

  assign wr_en       = sel & ~reg_read;
  assign claim_rd    = sel & reg_read & hit_claim;
  assign complete_wr = wr_en & hit_claim;
  assign complete_id = reg_wdata[src_id_w-1:0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      enable    <= '0;
      threshold <= '0;
      for (int i = 0; i < num_src; i++) begin
        prio[i] <= '0;
      end
    end else if (wr_en) begin
      if (hit_prio) begin
        prio[prio_idx] <= reg_wdata[prio_w-1:0];
      end
      if (hit_enable) begin
        enable <= {reg_wdata[num_src-1:1], 1'b0};
      end
      if (hit_threshold) begin
        threshold <= reg_wdata[prio_w-1:0];
      end
    end
  end

  always_comb begin
    rd_data = '0;
    if (hit_prio) begin
      rd_data[prio_w-1:0] = prio[prio_idx];
    end else if (hit_pending) begin
      rd_data[num_src-1:0] = pending;
    end else if (hit_enable) begin
      rd_data[num_src-1:0] = enable;
    end else if (hit_threshold) begin
      rd_data[prio_w-1:0] = threshold;
    end else if (hit_claim) begin
      rd_data[src_id_w-1:0] = claim_id;
    end
  end

  // Pending is read only
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rsp_valid <= 1'b0;
      rsp_err   <= 1'b0;
    end else begin
      rsp_valid <= sel;
      rsp_err   <= sel & (~hit_any | (hit_pending & ~reg_read));
    end
  end

  always_ff @(posedge clk) begin
    if (sel) begin
      rsp_rdata <= reg_read ? rd_data : '0;
    end
  end

endmodule

/* src/periph_icb_fabric.sv */
// ICB fabric routing one outstanding command to the CLINT or PLIC and returning its response
`timescale 1ns/1ns

module periph_icb_fabric (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             icb_cmd_valid,
  output logic             icb_cmd_ready,
  input  bus_pkg::addr_t   icb_cmd_addr,
  input  logic             icb_cmd_read,
  input  bus_pkg::data_t   icb_cmd_wdata,
  output logic             icb_rsp_valid,
  input  logic             icb_rsp_ready,
  output logic             icb_rsp_err,
  output bus_pkg::data_t   icb_rsp_rdata,
  output logic             clint_sel,
  output logic             plic_sel,
  output logic             reg_read,
  output bus_pkg::offset_t reg_offset,
  output bus_pkg::data_t   reg_wdata,
  input  logic             clint_rsp_valid,
  input  logic             clint_rsp_err,
  input  bus_pkg::data_t   clint_rsp_rdata,
  input  logic             plic_rsp_valid,
  input  logic             plic_rsp_err,
  input  bus_pkg::data_t   plic_rsp_rdata
);

  import bus_pkg::*;

  region_t cmd_region;
  logic    cmd_accept;
  logic    unmapped;
  logic    rsp_done;
  logic    busy;
  logic    tgt_valid;
  logic    tgt_err;
  data_t   tgt_rdata;
  logic    hold_valid;
  logic    hold_err;
  data_t   hold_rdata;

  ////////////////////////////////////////////////////////////////////
  // Command side
  always_comb begin
    if (icb_cmd_addr[addr_w-1:region_w] == clint_base[addr_w-1:region_w]) begin
      cmd_region = region_clint;
    end else if (icb_cmd_addr[addr_w-1:region_w] == plic_base[addr_w-1:region_w]) begin
      cmd_region = region_plic;
    end else begin
      cmd_region = region_none;
    end
  end

  assign icb_cmd_ready = ~busy;
  assign cmd_accept    = icb_cmd_valid & icb_cmd_ready;
  assign unmapped      = cmd_accept & (cmd_region == region_none);
  assign clint_sel     = cmd_accept & (cmd_region == region_clint);
  assign plic_sel      = cmd_accept & (cmd_region == region_plic);

  assign reg_read   = icb_cmd_read;
  assign reg_offset = icb_cmd_addr[region_w-1:0];
  assign reg_wdata  = icb_cmd_wdata;

  ////////////////////////////////////////////////////////////////////
  // Response side
  // Only one target can answer with one command in flight
  assign tgt_valid = clint_rsp_valid | plic_rsp_valid;
  assign tgt_err   = clint_rsp_valid ? clint_rsp_err : plic_rsp_err;
  assign tgt_rdata = clint_rsp_valid ? clint_rsp_rdata : plic_rsp_rdata;

  assign icb_rsp_valid = hold_valid | tgt_valid;
  assign icb_rsp_err   = hold_valid ? hold_err : tgt_err;
  assign icb_rsp_rdata = hold_valid ? hold_rdata : tgt_rdata;
  assign rsp_done      = icb_rsp_valid & icb_rsp_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy <= 1'b0;
    end else if (cmd_accept) begin
      busy <= 1'b1;
    end else if (rsp_done) begin
      busy <= 1'b0;
    end
  end

  // Holds an error reply or a target reply stalled by the master
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hold_valid <= 1'b0;
    end else if (unmapped || (tgt_valid && !icb_rsp_ready)) begin
      hold_valid <= 1'b1;
    end else if (rsp_done) begin
      hold_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (unmapped) begin
      hold_err   <= 1'b1;
      hold_rdata <= '0;
    end else if (tgt_valid) begin
      hold_err   <= tgt_err;
      hold_rdata <= tgt_rdata;
    end
  end

endmodule

/* src/periph_subsys.sv */
// Peripheral interrupt subsystem top with the ICB fabric and its CLINT and PLIC targets
`timescale 1ns/1ns

module periph_subsys (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              icb_cmd_valid,
  output logic              icb_cmd_ready,
  input  bus_pkg::addr_t    icb_cmd_addr,
  input  logic              icb_cmd_read,
  input  bus_pkg::data_t    icb_cmd_wdata,
  output logic              icb_rsp_valid,
  input  logic              icb_rsp_ready,
  output logic              icb_rsp_err,
  output bus_pkg::data_t    icb_rsp_rdata,
  input  irq_pkg::src_vec_t irq_src_a,
  input  logic              rtc_toggle_a,
  output logic              tmr_irq,
  output logic              sft_irq,
  output logic              ext_irq
);

  import bus_pkg::*;

  logic    clint_sel;
  logic    plic_sel;
  logic    reg_read;
  offset_t reg_offset;
  data_t   reg_wdata;

  logic    clint_rsp_valid;
  logic    clint_rsp_err;
  data_t   clint_rsp_rdata;
  logic    plic_rsp_valid;
  logic    plic_rsp_err;
  data_t   plic_rsp_rdata;

  periph_icb_fabric u_fabric (
    .clk             (clk),
    .rst_n           (rst_n),
    .icb_cmd_valid   (icb_cmd_valid),
    .icb_cmd_ready   (icb_cmd_ready),
    .icb_cmd_addr    (icb_cmd_addr),
    .icb_cmd_read    (icb_cmd_read),
    .icb_cmd_wdata   (icb_cmd_wdata),
    .icb_rsp_valid   (icb_rsp_valid),
    .icb_rsp_ready   (icb_rsp_ready),
    .icb_rsp_err     (icb_rsp_err),
    .icb_rsp_rdata   (icb_rsp_rdata),
    .clint_sel       (clint_sel),
    .plic_sel        (plic_sel),
    .reg_read        (reg_read),
    .reg_offset      (reg_offset),
    .reg_wdata       (reg_wdata),
    .clint_rsp_valid (clint_rsp_valid),
    .clint_rsp_err   (clint_rsp_err),
    .clint_rsp_rdata (clint_rsp_rdata),
    .plic_rsp_valid  (plic_rsp_valid),
    .plic_rsp_err    (plic_rsp_err),
    .plic_rsp_rdata  (plic_rsp_rdata)
  );

  clint_timer u_clint (
    .clk          (clk),
    .rst_n        (rst_n),
    .sel          (clint_sel),
    .reg_read     (reg_read),
    .reg_offset   (reg_offset),
    .reg_wdata    (reg_wdata),
    .rsp_valid    (clint_rsp_valid),
    .rsp_err      (clint_rsp_err),
    .rsp_rdata    (clint_rsp_rdata),
    .rtc_toggle_a (rtc_toggle_a),
    .tmr_irq      (tmr_irq),
    .sft_irq      (sft_irq)
  );

  plic_core u_plic (
    .clk        (clk),
    .rst_n      (rst_n),
    .sel        (plic_sel),
    .reg_read   (reg_read),
    .reg_offset (reg_offset),
    .reg_wdata  (reg_wdata),
    .rsp_valid  (plic_rsp_valid),
    .rsp_err    (plic_rsp_err),
    .rsp_rdata  (plic_rsp_rdata),
    .irq_src_a  (irq_src_a),
    .ext_irq    (ext_irq)
  );

endmodule

/* bench/periph_checker.sv */
// Checker that compares the subsystem bus responses and interrupt levels with expected values
`timescale 1ns/1ns

module periph_checker (
  input logic           clk,
  input logic           rst_n,
  input logic           icb_cmd_valid,
  input logic           icb_cmd_ready,
  input logic           icb_rsp_valid,
  input logic           icb_rsp_ready,
  input logic           icb_rsp_err,
  input bus_pkg::data_t icb_rsp_rdata,
  input logic           tmr_irq,
  input logic           sft_irq,
  input logic           ext_irq
);

  import bus_pkg::*;

  int value_errors;
  int protocol_errors;
  int irq_errors = 0;

  // Expected responses in issue order
  string exp_name  [int];
  data_t exp_rdata [int];
  logic  exp_err   [int];
  int    wr_count = 0;
  int    rd_idx;

  logic  outstanding;
  logic  accepted_last;
  logic  stalled_last;
  logic  err_last;
  data_t rdata_last;
  logic  after_reset;

  task automatic expect_response(input string name, input data_t rdata, input logic err);
    exp_name[wr_count]  = name;
    exp_rdata[wr_count] = rdata;
    exp_err[wr_count]   = err;
    wr_count++;
  endtask

  // Levels ordered as tmr, sft, ext
  task automatic check_irq(input string name, input logic [2:0] expected);
    logic [2:0] actual;
    actual = {tmr_irq, sft_irq, ext_irq};
    if (actual !== expected) begin
      irq_errors++;
      $display("CHECK FAILED %s: irq expected %b actual %b", name, expected, actual);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Handshake rules and response values
  always @(posedge clk) begin
    if (!rst_n) begin
      outstanding     = 1'b0;
      accepted_last   = 1'b0;
      stalled_last    = 1'b0;
      rd_idx          = 0;
      value_errors    = 0;
      protocol_errors = 0;
      after_reset     = 1'b1;
    end else begin
      if (after_reset) begin
        after_reset = 1'b0;
        if (!icb_cmd_ready || icb_rsp_valid || tmr_irq || sft_irq || ext_irq) begin
          protocol_errors++;
          $display("Outputs are not idle in the first cycle after reset");
        end
      end
      if (outstanding && icb_cmd_ready) begin
        protocol_errors++;
        $display("Command ready is high while a response is outstanding");
      end
      if (icb_rsp_valid && !outstanding) begin
        protocol_errors++;
        $display("Response is valid with no command outstanding");
      end
      if (accepted_last && !icb_rsp_valid) begin
        protocol_errors++;
        $display("Response did not arrive one cycle after acceptance");
      end
      if (stalled_last && (!icb_rsp_valid || icb_rsp_err !== err_last ||
                           icb_rsp_rdata !== rdata_last)) begin
        protocol_errors++;
        $display("Response changed while the master held it back");
      end
      if (icb_rsp_valid && icb_rsp_ready) begin
        if (rd_idx >= wr_count) begin
          protocol_errors++;
          $display("Response transferred with no expected value queued");
        end else begin
          if (icb_rsp_err !== exp_err[rd_idx]) begin
            value_errors++;
            $display("CHECK FAILED %s: err expected %0b actual %0b",
                     exp_name[rd_idx], exp_err[rd_idx], icb_rsp_err);
          end
          if (icb_rsp_rdata !== exp_rdata[rd_idx]) begin
            value_errors++;
            $display("CHECK FAILED %s: rdata expected %h actual %h",
                     exp_name[rd_idx], exp_rdata[rd_idx], icb_rsp_rdata);
          end
          rd_idx++;
        end
        outstanding = 1'b0;
      end
      accepted_last = icb_cmd_valid && icb_cmd_ready;
      if (accepted_last) begin
        outstanding = 1'b1;
      end
      stalled_last = icb_rsp_valid && !icb_rsp_ready;
      err_last     = icb_rsp_err;
      rdata_last   = icb_rsp_rdata;
    end
  end

endmodule

/* bench/tb_periph_subsys.sv */
// Peripheral subsystem testbench replaying bus and interrupt operations from a trace
`timescale 1ns/1ns

module tb_periph_subsys;

  import bus_pkg::*;
  import irq_pkg::*;

  localparam int    cycles_per_op = 40;
  localparam int    cycles_margin = 200;
  localparam int    max_stall     = 3;
  localparam int    sync_wait     = 6;
  localparam string trace_path    = "bench/periph_trace.txt";

  logic     clk = 1'b0;
  logic     rst_n;
  logic     icb_cmd_valid;
  logic     icb_cmd_ready;
  addr_t    icb_cmd_addr;
  logic     icb_cmd_read;
  data_t    icb_cmd_wdata;
  logic     icb_rsp_valid;
  logic     icb_rsp_ready;
  logic     icb_rsp_err;
  data_t    icb_rsp_rdata;
  src_vec_t irq_src_a;
  logic     rtc_toggle_a;
  logic     tmr_irq;
  logic     sft_irq;
  logic     ext_irq;

  // Trace contents with one entry per operation
  string      tr_name  [$];
  string      tr_op    [$];
  addr_t      tr_addr  [$];
  data_t      tr_data  [$];
  data_t      tr_rdata [$];
  logic       tr_err   [$];
  logic [2:0] tr_irq   [$];

  int trace_errors = 0;
  int cycle_limit  = 0;
  int cycle_count  = 0;
  int total_errors;

  always #4 clk = ~clk;

  periph_subsys i_periph_subsys (
    .clk           (clk),
    .rst_n         (rst_n),
    .icb_cmd_valid (icb_cmd_valid),
    .icb_cmd_ready (icb_cmd_ready),
    .icb_cmd_addr  (icb_cmd_addr),
    .icb_cmd_read  (icb_cmd_read),
    .icb_cmd_wdata (icb_cmd_wdata),
    .icb_rsp_valid (icb_rsp_valid),
    .icb_rsp_ready (icb_rsp_ready),
    .icb_rsp_err   (icb_rsp_err),
    .icb_rsp_rdata (icb_rsp_rdata),
    .irq_src_a     (irq_src_a),
    .rtc_toggle_a  (rtc_toggle_a),
    .tmr_irq       (tmr_irq),
    .sft_irq       (sft_irq),
    .ext_irq       (ext_irq)
  );

  periph_checker i_checker (
    .clk           (clk),
    .rst_n         (rst_n),
    .icb_cmd_valid (icb_cmd_valid),
    .icb_cmd_ready (icb_cmd_ready),
    .icb_rsp_valid (icb_rsp_valid),
    .icb_rsp_ready (icb_rsp_ready),
    .icb_rsp_err   (icb_rsp_err),
    .icb_rsp_rdata (icb_rsp_rdata),
    .tmr_irq       (tmr_irq),
    .sft_irq       (sft_irq),
    .ext_irq       (ext_irq)
  );

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Timeout after %0d cycles with the trace unfinished", cycle_count);
      $display("Regression failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Trace reader and drivers
  task automatic read_trace();
    int         fd;
    int         fields;
    string      line;
    string      name;
    string      op;
    addr_t      addr;
    data_t      data;
    data_t      rdata;
    logic       err;
    logic [2:0] irq;
    fd = $fopen(trace_path, "r");
    if (fd == 0) begin
      trace_errors++;
      $display("Cannot open trace file %s", trace_path);
    end else begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) > 0 && line.len() > 1 && line.getc(0) != "#") begin
          fields = $sscanf(line, "%s %s %h %h %h %h %b", name, op, addr, data, rdata, err, irq);
          if (fields == 7) begin
            tr_name.push_back(name);
            tr_op.push_back(op);
            tr_addr.push_back(addr);
            tr_data.push_back(data);
            tr_rdata.push_back(rdata);
            tr_err.push_back(err);
            tr_irq.push_back(irq);
          end else begin
            trace_errors++;
            $display("Malformed trace line: %s", line);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic idle_cycles(input int count);
    repeat (count) @(posedge clk);
  endtask

  // One command followed by a random hold-off on rsp_ready
  task automatic bus_access(input string name, input addr_t addr, input logic rd,
                            input data_t wdata, input data_t exp_rdata, input logic exp_err);
    int stall;
    int waited;
    i_checker.expect_response(name, exp_rdata, exp_err);
    stall = $urandom_range(max_stall, 0);
    @(posedge clk);
    icb_cmd_valid <= 1'b1;
    icb_cmd_addr  <= addr;
    icb_cmd_read  <= rd;
    icb_cmd_wdata <= wdata;
    @(posedge clk);
    while (!icb_cmd_ready) @(posedge clk);
    icb_cmd_valid <= 1'b0;
    icb_rsp_ready <= (stall == 0);
    waited = 0;
    @(posedge clk);
    while (!(icb_rsp_valid && icb_rsp_ready)) begin
      waited++;
      if (waited >= stall) begin
        icb_rsp_ready <= 1'b1;
      end
      @(posedge clk);
    end
    icb_rsp_ready <= 1'b0;
  endtask

  task automatic set_sources(input src_vec_t levels);
    @(posedge clk);
    irq_src_a <= levels;
    idle_cycles(sync_wait);
  endtask

  // Each toggle is one full pulse long enough for the synchronizer
  task automatic toggle_rtc(input int count);
    repeat (count) begin
      @(posedge clk);
      rtc_toggle_a <= 1'b1;
      idle_cycles(3);
      rtc_toggle_a <= 1'b0;
      idle_cycles(2);
    end
    idle_cycles(sync_wait);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  initial begin
    rst_n         <= 1'b0;
    icb_cmd_valid <= 1'b0;
    icb_cmd_addr  <= '0;
    icb_cmd_read  <= 1'b0;
    icb_cmd_wdata <= '0;
    icb_rsp_ready <= 1'b0;
    irq_src_a     <= '0;
    rtc_toggle_a  <= 1'b0;
    void'($urandom(42484));
    read_trace();
    cycle_limit = tr_name.size() * cycles_per_op + cycles_margin;
    if (trace_errors == 0) begin
      idle_cycles(10);
      rst_n <= 1'b1;
      for (int i = 0; i < tr_name.size(); i++) begin
        case (tr_op[i])
          "wr":    bus_access(tr_name[i], tr_addr[i], 1'b0, tr_data[i], tr_rdata[i], tr_err[i]);
          "rd":    bus_access(tr_name[i], tr_addr[i], 1'b1, tr_data[i], tr_rdata[i], tr_err[i]);
          "src":   set_sources(src_vec_t'(tr_data[i]));
          "rtc":   toggle_rtc(int'(tr_data[i]));
          "wait":  idle_cycles(int'(tr_data[i]));
          "irq": begin
            @(posedge clk);
            i_checker.check_irq(tr_name[i], tr_irq[i]);
          end
          default: begin
            trace_errors++;
            $display("Unknown operation %s in test %s", tr_op[i], tr_name[i]);
          end
        endcase
      end
      idle_cycles(4);
    end
    total_errors = i_checker.value_errors + i_checker.irq_errors +
                   i_checker.protocol_errors + trace_errors;
    $display("Error counts: response %0d, irq %0d, protocol %0d, trace %0d",
             i_checker.value_errors, i_checker.irq_errors,
             i_checker.protocol_errors, trace_errors);
    if (total_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* list.f */
src/bus_pkg.sv
src/irq_pkg.sv
src/clint_timer.sv
src/plic_core.sv
src/periph_icb_fabric.sv
src/periph_subsys.sv
bench/periph_checker.sv
bench/tb_periph_subsys.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_periph_subsys
FLIST     ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Regression passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* bench/periph_trace.txt */
# test op addr data exp_rdata exp_err exp_irq(tmr sft ext, binary)
# ops: wr rd src rtc wait irq; src, rtc and wait take their value from the data column
rst_irq      irq  00000000 00000000 00000000 0 000
rst_cmp_lo   rd   02004000 00000000 ffffffff 0 000
rst_cmp_hi   rd   02004004 00000000 ffffffff 0 000
rst_claim    rd   0c003004 00000000 00000000 0 000
unmap_rd     rd   10000000 00000000 00000000 1 000
unmap_wr     wr   02010000 12345678 00000000 1 000
clint_bad    rd   02000004 00000000 00000000 1 000
plic_bad     rd   0c000020 00000000 00000000 1 000
pend_wr      wr   0c001000 000000ff 00000000 1 000
msip_set     wr   02000000 00000001 00000000 0 000
msip_irq     irq  00000000 00000000 00000000 0 010
msip_rd      rd   02000000 00000000 00000001 0 000
msip_clr     wr   02000000 00000000 00000000 0 000
mtime_lo_wr  wr   0200bff8 00000100 00000000 0 000
mtime_lo_rd  rd   0200bff8 00000000 00000100 0 000
cmp_hi_wr    wr   02004004 00000000 00000000 0 000
cmp_lo_wr    wr   02004000 00000103 00000000 0 000
cmp_lo_rd    rd   02004000 00000000 00000103 0 000
tmr_below    irq  00000000 00000000 00000000 0 000
rtc_two      rtc  00000000 00000002 00000000 0 000
mtime_two    rd   0200bff8 00000000 00000102 0 000
tmr_still    irq  00000000 00000000 00000000 0 000
rtc_one      rtc  00000000 00000001 00000000 0 000
tmr_reach    irq  00000000 00000000 00000000 0 100
mtime_three  rd   0200bff8 00000000 00000103 0 000
cmp_lo_up    wr   02004000 00000200 00000000 0 000
tmr_clear    irq  00000000 00000000 00000000 0 000
prio1_wr     wr   0c000004 00000002 00000000 0 000
prio3_wr     wr   0c00000c 00000005 00000000 0 000
prio5_wr     wr   0c000014 00000005 00000000 0 000
prio6_wr     wr   0c000018 00000007 00000000 0 000
prio3_rd     rd   0c00000c 00000000 00000005 0 000
enable_wr    wr   0c002000 0000002a 00000000 0 000
enable_rd    rd   0c002000 00000000 0000002a 0 000
thresh_wr    wr   0c003000 00000001 00000000 0 000
no_src       irq  00000000 00000000 00000000 0 000
src_on       src  00000000 0000006a 00000000 0 000
ext_on       irq  00000000 00000000 00000000 0 001
pend_all     rd   0c001000 00000000 0000006a 0 000
claim_tie    rd   0c003004 00000000 00000003 0 000
pend_less3   rd   0c001000 00000000 00000062 0 000
claim_next   rd   0c003004 00000000 00000005 0 000
claim_low    rd   0c003004 00000000 00000001 0 000
claim_none   rd   0c003004 00000000 00000000 0 000
ext_busy     irq  00000000 00000000 00000000 0 000
complete3    wr   0c003004 00000003 00000000 0 000
settle       wait 00000000 00000002 00000000 0 000
ext_back     irq  00000000 00000000 00000000 0 001
thresh_hi    wr   0c003000 00000005 00000000 0 000
ext_masked   irq  00000000 00000000 00000000 0 000
claim_mask   rd   0c003004 00000000 00000000 0 000
thresh_mid   wr   0c003000 00000004 00000000 0 000
claim_again  rd   0c003004 00000000 00000003 0 000
enable_six   wr   0c002000 0000006a 00000000 0 000
claim_top    rd   0c003004 00000000 00000006 0 000
pend_none    rd   0c001000 00000000 00000000 0 000
src_off      src  00000000 00000000 00000000 0 000
end_irq      irq  00000000 00000000 00000000 0 000
